// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_mips_pipeline
FILELIST ?= files.f
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input mips_pkg::id_ex_t id_ex,
	input logic [1:0] fwd_a,
	input logic [1:0] fwd_b,
	input logic [mips_pkg::data_w-1:0] mem_fwd_data,
	input logic [mips_pkg::data_w-1:0] wb_data,
	output mips_pkg::ex_mem_t ex_mem
);
	import mips_pkg::*;

	logic [data_w-1:0] op_a;
	logic [data_w-1:0] rt_val;
	logic [data_w-1:0] op_b;
	logic [data_w-1:0] result;

	function automatic logic [data_w-1:0] fwd_mux(
		input logic [1:0] sel,
		input logic [data_w-1:0] reg_val,
		input logic [data_w-1:0] mem_val,
		input logic [data_w-1:0] wb_val
	);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a, id_ex.rs_data, mem_fwd_data, wb_data);
	assign rt_val = fwd_mux(fwd_b, id_ex.rt_data, mem_fwd_data, wb_data);
	assign op_b = (id_ex.alu_src == src_reg) ? rt_val : id_ex.imm;

	always_comb begin
		case (id_ex.alu_ctrl)
			alu_and: result = op_a & op_b;
			alu_or: result = op_a | op_b;
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_slt: result = {{(data_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_xor: result = op_a ^ op_b;
			alu_nor: result = ~(op_a | op_b);
			alu_sll: result = rt_val << id_ex.shamt;
			alu_srl: result = rt_val >> id_ex.shamt; // logical
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else if (!stall) begin
			ex_mem <= '{
				reg_write: id_ex.reg_write,
				mem_read: id_ex.mem_read,
				mem_write: id_ex.mem_write,
				rd: id_ex.rd,
				alu_result: result,
				store_data: rt_val
			};
		end
	end

endmodule

`default_nettype wire

// File: files.f
mips_pkg.sv
inst_fetch.sv
inst_decode.sv
reg_file.sv
hazard_forward.sv
execute.sv
mem_writeback.sv
mips_pipeline.sv
tb_mips_pipeline.sv

// File: hazard_forward.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_forward (
	input logic [mips_pkg::reg_addr_w-1:0] rs,
	input logic [mips_pkg::reg_addr_w-1:0] rt,
	input mips_pkg::id_ex_t id_ex,
	input logic [mips_pkg::reg_addr_w-1:0] mem_rd,
	input logic [mips_pkg::reg_addr_w-1:0] wb_rd,
	output logic load_hold,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b
);
	import mips_pkg::*;

	logic ex_load;

	function automatic logic [1:0] fwd_sel(
		input logic [reg_addr_w-1:0] src,
		input logic [reg_addr_w-1:0] m_rd,
		input logic [reg_addr_w-1:0] w_rd
	);
		if (src == '0)
			return fwd_none;
		if (src == m_rd)
			return fwd_mem; // nearest producer wins
		if (src == w_rd)
			return fwd_wb;
		return fwd_none;
	endfunction

	// load data only exists after the memory stage
	assign ex_load = id_ex.mem_read && (id_ex.rd != '0);
	assign load_hold = ex_load && ((id_ex.rd == rs) || (id_ex.rd == rt));

	assign fwd_a = fwd_sel(id_ex.rs, mem_rd, wb_rd);
	assign fwd_b = fwd_sel(id_ex.rt, mem_rd, wb_rd);

endmodule

`default_nettype wire

// File: inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic load_hold,
	input mips_pkg::instr_t instr,
	input logic [mips_pkg::data_w-1:0] rs_data,
	input logic [mips_pkg::data_w-1:0] rt_data,
	output logic [mips_pkg::reg_addr_w-1:0] rs,
	output logic [mips_pkg::reg_addr_w-1:0] rt,
	output mips_pkg::id_ex_t id_ex
);
	import mips_pkg::*;

	id_ex_t dec;
	id_ex_t nxt;
	logic reads_rs;
	logic reads_rt;

	always_comb begin
		dec = '0;
		reads_rs = 1'b1;
		reads_rt = 1'b0;
		dec.alu_src = src_sext;
		dec.alu_ctrl = alu_add;
		dec.rd = instr.r.rt; // i-type destination
		case (instr.r.opcode)
			op_rtype: begin
				dec.alu_src = src_reg;
				dec.rd = instr.r.rd;
				dec.reg_write = 1'b1;
				reads_rt = 1'b1;
				case (instr.r.funct)
					fn_add: dec.alu_ctrl = alu_add;
					fn_sub: dec.alu_ctrl = alu_sub;
					fn_and: dec.alu_ctrl = alu_and;
					fn_or: dec.alu_ctrl = alu_or;
					fn_xor: dec.alu_ctrl = alu_xor;
					fn_nor: dec.alu_ctrl = alu_nor;
					fn_slt: dec.alu_ctrl = alu_slt;
					fn_sll: begin
						dec.alu_ctrl = alu_sll;
						reads_rs = 1'b0; // shifts take rt only
					end
					fn_srl: begin
						dec.alu_ctrl = alu_srl;
						reads_rs = 1'b0;
					end
					default: begin
						dec.reg_write = 1'b0;
						reads_rs = 1'b0;
						reads_rt = 1'b0;
					end
				endcase
			end
			op_lw: begin
				dec.mem_read = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_sw: begin
				dec.mem_write = 1'b1;
				reads_rt = 1'b1; // store data
			end
			op_addi: dec.reg_write = 1'b1;
			op_andi: begin
				dec.reg_write = 1'b1;
				dec.alu_src = src_zext;
				dec.alu_ctrl = alu_and;
			end
			op_ori: begin
				dec.reg_write = 1'b1;
				dec.alu_src = src_zext;
				dec.alu_ctrl = alu_or;
			end
			op_xori: begin
				dec.reg_write = 1'b1;
				dec.alu_src = src_zext;
				dec.alu_ctrl = alu_xor;
			end
			op_slti: begin
				dec.reg_write = 1'b1;
				dec.alu_ctrl = alu_slt;
			end
			default: reads_rs = 1'b0; // no-op
		endcase
		if (!dec.reg_write)
			dec.rd = '0;
		rs = reads_rs ? instr.r.rs : '0;
		rt = reads_rt ? instr.r.rt : '0;
		dec.rs = rs;
		dec.rt = rt;
		dec.shamt = instr.r.shamt;
		if (dec.alu_src == src_zext)
			dec.imm = {16'd0, instr.i.imm};
		else
			dec.imm = {{16{instr.i.imm[15]}}, instr.i.imm};
	end

	always_comb begin
		nxt = dec;
		nxt.rs_data = rs_data;
		nxt.rt_data = rt_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_ex <= '0;
		else if (!stall)
			id_ex <= load_hold ? '0 : nxt; // bubble behind a load
	end

endmodule

`default_nettype wire

// File: inst_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module inst_fetch (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic load_hold,
	input mips_pkg::instr_t icache_rdata,
	output logic icache_ren,
	output logic [mips_pkg::cache_addr_w-1:0] icache_addr,
	output mips_pkg::instr_t instr
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			icache_ren <= 1'b0;
			icache_addr <= '0;
			instr <= '0;
		end else begin
			icache_ren <= 1'b1;
			if (!(stall || load_hold)) begin
				icache_addr <= icache_addr + 1'b1; // next word
				instr <= icache_rdata;
			end
		end
	end

	pc_frozen_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(icache_addr));

endmodule

`default_nettype wire

// File: mem_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module mem_writeback (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input mips_pkg::ex_mem_t ex_mem,
	input logic [mips_pkg::data_w-1:0] dcache_rdata,
	output mips_pkg::dcache_req_t dcache,
	output logic [mips_pkg::data_w-1:0] mem_fwd_data,
	output mips_pkg::mem_wb_t mem_wb
);
	import mips_pkg::*;

	assign dcache = '{
		ren: ex_mem.mem_read,
		wen: ex_mem.mem_write,
		addr: ex_mem.alu_result[data_w-1:2], // byte to word address
		wdata: ex_mem.store_data
	};

	assign mem_fwd_data = ex_mem.mem_read ? dcache_rdata : ex_mem.alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_wb <= '0;
		else if (!stall)
			mem_wb <= '{reg_write: ex_mem.reg_write, rd: ex_mem.rd, result: mem_fwd_data};
	end

	dcache_rw_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		!(dcache.ren && dcache.wen));

	dcache_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(dcache));

endmodule

`default_nettype wire

// File: mips_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline (
	input logic clk,
	input logic rst_n,
	output logic icache_ren,
	output logic [mips_pkg::cache_addr_w-1:0] icache_addr,
	input mips_pkg::instr_t icache_rdata,
	input logic icache_stall,
	output mips_pkg::dcache_req_t dcache,
	input logic [mips_pkg::data_w-1:0] dcache_rdata,
	input logic dcache_stall
);
	import mips_pkg::*;

	logic stall;
	logic load_hold;
	instr_t instr;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [data_w-1:0] rs_data;
	logic [data_w-1:0] rt_data;
	logic [data_w-1:0] mem_fwd_data;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	assign stall = icache_stall || dcache_stall; // freezes every stage

	inst_fetch u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.load_hold(load_hold),
		.icache_rdata(icache_rdata),
		.icache_ren(icache_ren),
		.icache_addr(icache_addr),
		.instr(instr)
	);

	inst_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.load_hold(load_hold),
		.instr(instr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.rs(rs),
		.rt(rt),
		.id_ex(id_ex)
	);

	reg_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.rs(rs),
		.rt(rt),
		.wb(mem_wb),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	hazard_forward u_hazard (
		.rs(rs),
		.rt(rt),
		.id_ex(id_ex),
		.mem_rd(ex_mem.rd),
		.wb_rd(mem_wb.rd),
		.load_hold(load_hold),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	execute u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.id_ex(id_ex),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.mem_fwd_data(mem_fwd_data),
		.wb_data(mem_wb.result),
		.ex_mem(ex_mem)
	);

	mem_writeback u_mem_wb (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.ex_mem(ex_mem),
		.dcache_rdata(dcache_rdata),
		.dcache(dcache),
		.mem_fwd_data(mem_fwd_data),
		.mem_wb(mem_wb)
	);

endmodule

`default_nettype wire

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int data_w = 32;
	localparam int reg_addr_w = 5;
	localparam int cache_addr_w = data_w - 2; // word address

	localparam logic [5:0] op_rtype = 6'd0;
	localparam logic [5:0] op_lw = 6'd35;
	localparam logic [5:0] op_sw = 6'd43;
	localparam logic [5:0] op_addi = 6'd8;
	localparam logic [5:0] op_andi = 6'd12;
	localparam logic [5:0] op_ori = 6'd13;
	localparam logic [5:0] op_xori = 6'd14;
	localparam logic [5:0] op_slti = 6'd10;

	localparam logic [5:0] fn_add = 6'd32;
	localparam logic [5:0] fn_sub = 6'd34;
	localparam logic [5:0] fn_and = 6'd36;
	localparam logic [5:0] fn_or = 6'd37;
	localparam logic [5:0] fn_xor = 6'd38;
	localparam logic [5:0] fn_nor = 6'd39;
	localparam logic [5:0] fn_slt = 6'd42;
	localparam logic [5:0] fn_sll = 6'd0;
	localparam logic [5:0] fn_srl = 6'd2;

	localparam logic [3:0] alu_and = 4'b0000;
	localparam logic [3:0] alu_or = 4'b0001;
	localparam logic [3:0] alu_add = 4'b0010;
	localparam logic [3:0] alu_xor = 4'b0011;
	localparam logic [3:0] alu_nor = 4'b0100;
	localparam logic [3:0] alu_sll = 4'b0101;
	localparam logic [3:0] alu_sub = 4'b0110;
	localparam logic [3:0] alu_slt = 4'b0111;
	localparam logic [3:0] alu_srl = 4'b1000;

	localparam logic [1:0] src_reg = 2'b00;
	localparam logic [1:0] src_sext = 2'b01;
	localparam logic [1:0] src_zext = 2'b11;

	localparam logic [1:0] fwd_none = 2'b00;
	localparam logic [1:0] fwd_wb = 2'b01;
	localparam logic [1:0] fwd_mem = 2'b10;

	typedef struct packed {
		logic [5:0] opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic [3:0] alu_ctrl;
		logic [1:0] alu_src;
		logic [4:0] shamt;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd; // zero when nothing is written
		logic [data_w-1:0] rs_data;
		logic [data_w-1:0] rt_data;
		logic [data_w-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic [reg_addr_w-1:0] rd;
		logic [data_w-1:0] alu_result;
		logic [data_w-1:0] store_data;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		logic [reg_addr_w-1:0] rd;
		logic [data_w-1:0] result;
	} mem_wb_t;

	typedef struct packed {
		logic ren;
		logic wen;
		logic [cache_addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} dcache_req_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [mips_pkg::reg_addr_w-1:0] rs,
	input logic [mips_pkg::reg_addr_w-1:0] rt,
	input mips_pkg::mem_wb_t wb,
	output logic [mips_pkg::data_w-1:0] rs_data,
	output logic [mips_pkg::data_w-1:0] rt_data
);
	import mips_pkg::*;

	logic [data_w-1:0] regs [1:31]; // r0 is not stored
	logic wr_en;

	assign wr_en = wb.reg_write && (wb.rd != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.rd] <= wb.result;
		end
	end

	always_comb begin
		if (rs == '0)
			rs_data = '0;
		else if (wr_en && (rs == wb.rd))
			rs_data = wb.result; // write-through
		else
			rs_data = regs[rs];
	end

	always_comb begin
		if (rt == '0)
			rt_data = '0;
		else if (wr_en && (rt == wb.rd))
			rt_data = wb.result;
		else
			rt_data = regs[rt];
	end

	r0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rs != '0 || rs_data == '0) && (rt != '0 || rt_data == '0));

endmodule

`default_nettype wire

// File: tb_mips_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_pipeline;
	import mips_pkg::*;

	localparam int period = 100;
	localparam int prog_words = 64;
	localparam int body_len = 40;
	localparam int prog_len = body_len + 7; // body plus the closing stores
	localparam int max_run = 4;
	localparam int n_tests = 4;
	localparam int watchdog_ns = n_tests * (prog_words * 4 * max_run + 16) * period;
	localparam logic [5:0] r_functs [0:8] = '{fn_add, fn_sub, fn_and, fn_or, fn_xor,
		fn_nor, fn_slt, fn_sll, fn_srl};
	localparam logic [5:0] i_ops [0:4] = '{op_addi, op_andi, op_ori, op_xori, op_slti};

	logic clk;
	logic rst_n;
	logic icache_ren;
	logic [cache_addr_w-1:0] icache_addr;
	instr_t icache_rdata;
	logic icache_stall;
	dcache_req_t dcache;
	logic [data_w-1:0] dcache_rdata;
	logic dcache_stall;

	integer seed;
	instr_t prog [0:prog_words-1];
	logic [data_w-1:0] dmem [0:31];
	logic [data_w-1:0] ref_mem [0:31];
	dcache_req_t exp_q [$];
	string cur_test;
	int n_checks;
	int n_errors;
	int test_errors;
	int n_req;
	int since_rst;
	int ic_run;
	int dc_run;
	bit stall_en;
	logic [cache_addr_w-1:0] prev_addr;
	dcache_req_t prev_req;
	logic prev_stall;

	mips_pipeline dut (
		.clk(clk),
		.rst_n(rst_n),
		.icache_ren(icache_ren),
		.icache_addr(icache_addr),
		.icache_rdata(icache_rdata),
		.icache_stall(icache_stall),
		.dcache(dcache),
		.dcache_rdata(dcache_rdata),
		.dcache_stall(dcache_stall)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	function automatic int unsigned rnd(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			test_errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic gen_program(input bit with_mem);
		instr_t w;
		int unsigned k;
		for (int i = 0; i < prog_words; i++)
			prog[i] = '0; // padding decodes as no-op
		for (int i = 0; i < 32; i++) begin
			dmem[i] = $random(seed);
			ref_mem[i] = dmem[i];
		end
		for (int i = 0; i < body_len; i++) begin
			w = '0;
			k = rnd(with_mem ? 20 : 14);
			if (k < 9) begin
				w.r.opcode = op_rtype;
				w.r.rs = 5'(rnd(8));
				w.r.rt = 5'(rnd(8));
				w.r.rd = 5'(rnd(8));
				w.r.funct = r_functs[k];
				if (k >= 7)
					w.r.shamt = 5'(rnd(32)); // shifts only
			end else if (k < 14) begin
				w.i.opcode = i_ops[k - 9];
				w.i.rs = 5'(rnd(8));
				w.i.rt = 5'(rnd(8));
				w.i.imm = 16'($random(seed));
			end else begin
				w.i.opcode = (k < 17) ? op_lw : op_sw;
				w.i.rt = 5'(rnd(8));
				w.i.imm = 16'(rnd(16) * 4); // words 0 to 15 off r0
			end
			prog[i] = w;
		end
		for (int r = 1; r < 8; r++) begin
			w = '0;
			w.i.opcode = op_sw;
			w.i.rt = 5'(r);
			w.i.imm = 16'(64 + 4 * r);
			prog[body_len + r - 1] = w;
		end
	endtask

	// in-order ISA interpreter, builds the expected load and store stream
	task automatic run_reference();
		logic [data_w-1:0] regs_m [0:31];
		instr_t w;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] simm;
		logic [data_w-1:0] zimm;
		logic [data_w-1:0] res;
		logic [data_w-1:0] addr;
		logic [4:0] dst;
		logic wr;
		for (int i = 0; i < 32; i++)
			regs_m[i] = '0;
		exp_q.delete();
		for (int pc = 0; pc < prog_len; pc++) begin
			w = prog[pc];
			a = regs_m[w.r.rs];
			b = regs_m[w.r.rt];
			simm = {{16{w.i.imm[15]}}, w.i.imm};
			zimm = {16'd0, w.i.imm};
			wr = 1'b1;
			dst = w.i.rt;
			res = '0;
			case (w.r.opcode)
				op_rtype: begin
					dst = w.r.rd;
					case (w.r.funct)
						fn_add: res = a + b;
						fn_sub: res = a - b;
						fn_and: res = a & b;
						fn_or: res = a | b;
						fn_xor: res = a ^ b;
						fn_nor: res = ~(a | b);
						fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						fn_sll: res = b << w.r.shamt;
						fn_srl: res = b >> w.r.shamt;
						default: wr = 1'b0;
					endcase
				end
				op_addi: res = a + simm;
				op_andi: res = a & zimm;
				op_ori: res = a | zimm;
				op_xori: res = a ^ zimm;
				op_slti: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
				op_lw: begin
					addr = a + simm;
					res = ref_mem[addr[6:2]];
					exp_q.push_back(dcache_req_t'{ren: 1'b1, wen: 1'b0,
						addr: addr[31:2], wdata: '0});
				end
				op_sw: begin
					addr = a + simm;
					ref_mem[addr[6:2]] = b;
					exp_q.push_back(dcache_req_t'{ren: 1'b0, wen: 1'b1,
						addr: addr[31:2], wdata: b});
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0)
				regs_m[dst] = res;
		end
	endtask

	// cache models, driven just after the rising edge
	always @(posedge clk) begin
		#1;
		icache_rdata = (icache_addr < prog_words) ? prog[icache_addr[5:0]] : '0;
		dcache_rdata = dmem[dcache.addr[4:0]];
		if (stall_en) begin
			if (ic_run == 0 && rnd(4) == 0)
				ic_run = 1 + rnd(max_run);
			if (dc_run == 0 && rnd(4) == 0)
				dc_run = 1 + rnd(max_run);
			icache_stall = ic_run > 0;
			dcache_stall = dc_run > 0;
			if (ic_run > 0)
				ic_run--;
			if (dc_run > 0)
				dc_run--;
		end else begin
			ic_run = 0;
			dc_run = 0;
			icache_stall = 1'b0;
			dcache_stall = 1'b0;
		end
	end

	task automatic take_request();
		dcache_req_t act;
		act = dcache;
		n_req++;
		if (exp_q.size() == 0) begin
			n_errors++;
			test_errors++;
			$display("%s: data cache request at word %h with none left in the program",
				cur_test, act.addr);
		end else begin
			check({cur_test, " memory request"}, exp_q.pop_front(), act);
		end
		if (dcache.wen)
			dmem[dcache.addr[4:0]] = dcache.wdata;
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst_n || since_rst == 0) begin
			check({cur_test, " reset"}, '0, {icache_ren, dcache.ren, dcache.wen, icache_addr});
		end else begin
			check({cur_test, " icache_ren"}, 64'd1, icache_ren);
			if (prev_stall) begin
				check({cur_test, " fetch hold"}, prev_addr, icache_addr);
				check({cur_test, " dcache hold"}, prev_req, dcache);
			end else if (icache_addr != prev_addr) begin
				check({cur_test, " fetch step"}, prev_addr + 30'd1, icache_addr);
			end
			if (!icache_stall && !dcache_stall && (dcache.ren || dcache.wen))
				take_request();
		end
		since_rst = rst_n ? since_rst + 1 : 0;
		prev_addr = icache_addr;
		prev_req = dcache;
		prev_stall = icache_stall || dcache_stall;
	end

	task automatic run_test(input string name, input bit with_mem, input bit with_stall);
		@(negedge clk);
		stall_en = 1'b0;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		cur_test = name;
		test_errors = 0;
		n_req = 0;
		gen_program(with_mem);
		run_reference();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		stall_en = with_stall;
		while (exp_q.size() != 0 || icache_addr < prog_len)
			@(negedge clk);
		repeat (4) @(negedge clk); // catch stray requests
		$display("test %s done: %0d memory requests, %0d errors", name, n_req, test_errors);
	endtask

	initial begin
		seed = 32'h4f9b;
		rst_n = 1'b0;
		icache_rdata = '0;
		icache_stall = 1'b0;
		dcache_rdata = '0;
		dcache_stall = 1'b0;
		stall_en = 1'b0;
		ic_run = 0;
		dc_run = 0;
		since_rst = 0;
		n_checks = 0;
		n_errors = 0;
		cur_test = "init";
		run_test("alu_ops", 1'b0, 1'b0);
		run_test("fwd_load_use", 1'b1, 1'b0);
		run_test("stall_mem", 1'b1, 1'b1);
		run_test("stall_alu", 1'b0, 1'b1);
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog: the tests did not finish within %0d ns", watchdog_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
